/* hw/heapCfg.svh */
/*
  Size defines for the array heap: array count, array length,
  element width, request queue depth and response credits
*/
`ifndef HEAP_CFG_SVH
`define HEAP_CFG_SVH

// ------------------------------------------------
// Heap geometry
// ------------------------------------------------
`define HEAP_ARRAYS        4   // Arrays in the heap, all allocatable
`define HEAP_ARRAY_LENGTH  4   // Max elements per array
`define HEAP_DATA_BITS    12   // Element width

// ------------------------------------------------
// Flow control
// ------------------------------------------------
`define HEAP_QUEUE_DEPTH   4   // Request FIFO entries, client start credits
`define HEAP_RSP_CREDITS   2   // Responses the consumer can absorb

`endif

/* hw/heapPkg.sv */
/*
  Heap types: opcode and status enums, derived widths,
  request, response and allocator grant structs
*/
`default_nettype none
`include "heapCfg.svh"

package heapPkg;

  // ------------------------------------------------
  // Derived widths
  // ------------------------------------------------
  localparam int ARRAY_BITS = (`HEAP_ARRAYS > 1) ? $clog2(`HEAP_ARRAYS) : 1;
  localparam int INDEX_BITS = (`HEAP_ARRAY_LENGTH > 1) ? $clog2(`HEAP_ARRAY_LENGTH) : 1;
  localparam int SIZE_BITS  = $clog2(`HEAP_ARRAY_LENGTH + 1);   // Holds 0 to full length
  localparam int DATA_BITS  = `HEAP_DATA_BITS;

  typedef logic [ARRAY_BITS-1:0] arrayNum;
  typedef logic [INDEX_BITS-1:0] elemIndex;
  typedef logic [SIZE_BITS-1:0]  sizeCount;
  typedef logic [DATA_BITS-1:0]  dataWord;

  typedef enum logic [3:0] {
    opAlloc, opFree, opWrite, opRead, opSize, opPush, opPop,
    opAdd, opSub, opOr, opXor, opAnd
  } heapOp;

  typedef enum logic [2:0] {
    stOk, stNotAllocated, stFreed, stOutOfBounds, stFull, stEmpty, stOutOfMemory
  } heapStatus;

  typedef struct packed {
    heapOp    op;      // Requested operation
    arrayNum  array;   // Target array, ignored by alloc
    elemIndex index;   // Element within array
    dataWord  data;    // Operand
  } heapReq;

  typedef struct packed {
    heapStatus status;
    dataWord   data;   // Zero on any error
  } heapRsp;

  typedef struct packed {
    heapStatus status;  // Array validity or out of memory
    logic      alloc;   // Head request is an alloc
    arrayNum   array;   // Picked array on alloc, else requested one
  } heapGrant;

endpackage

`default_nettype wire

/* hw/heapRequestQueue.sv */
/*
  Request input FIFO, circular with a count
  Returns one credit per request popped
*/
`timescale 1ns/100ps
`default_nettype none
`include "heapCfg.svh"

module heapRequestQueue (
  input  wire logic            clock,
  input  wire logic            resetN,
  input  wire logic            reqValid,    // Client sends only with a credit
  input  wire heapPkg::heapReq reqData,
  input  wire logic            execute,     // Head consumed this cycle
  output logic                 headValid,
  output heapPkg::heapReq      head,
  output logic                 reqCredit
);

  localparam int DEPTH      = `HEAP_QUEUE_DEPTH;
  localparam int PTR_BITS   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int COUNT_BITS = $clog2(DEPTH + 1);

  heapPkg::heapReq       entries [DEPTH];   // Payload storage
  logic [PTR_BITS-1:0]   wrPtr;
  logic [PTR_BITS-1:0]   rdPtr;
  logic [COUNT_BITS-1:0] count;

  function automatic logic [PTR_BITS-1:0] nextPtr(input logic [PTR_BITS-1:0] ptr);
    return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;   // Wrap for any depth
  endfunction

  // ------------------------------------------------
  // Pointers and occupancy
  // ------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (reqValid) wrPtr <= nextPtr(wrPtr);
      if (execute)  rdPtr <= nextPtr(rdPtr);
      case ({reqValid, execute})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;          // Idle, or push and pop together
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reqValid) entries[wrPtr] <= reqData;
  end

  assign headValid = (count != '0);
  assign head      = entries[rdPtr];
  assign reqCredit = execute;         // Freed slot goes straight back to the client

  // A send into a full queue means the client overran its credits
  assert property (@(posedge clock) disable iff (!resetN)
    reqValid |-> count < COUNT_BITS'(DEPTH));

endmodule

`default_nettype wire

/* hw/heapAllocator.sv */
/*
  Array allocator: allocation flags, LIFO of freed arrays,
  high-water mark of arrays ever used, validity check per request
*/
`timescale 1ns/100ps
`default_nettype none
`include "heapCfg.svh"

module heapAllocator (
  input  wire logic            clock,
  input  wire logic            resetN,
  input  wire logic            execute,
  input  wire heapPkg::heapReq head,
  output heapPkg::heapGrant    grant
);

  localparam int ARRAYS     = `HEAP_ARRAYS;
  localparam int COUNT_BITS = $clog2(ARRAYS + 1);

  logic                  allocated [ARRAYS];   // Array currently handed out
  heapPkg::arrayNum      freeStack [ARRAYS];   // Freed arrays, newest on top
  logic [COUNT_BITS-1:0] stackTop;             // Entries on the free stack
  logic [COUNT_BITS-1:0] usedCount;            // High-water mark
  heapPkg::arrayNum      topIndex;

  assign topIndex = heapPkg::arrayNum'(stackTop - 1'b1);

  // ------------------------------------------------
  // Grant for the head request
  // ------------------------------------------------
  always_comb begin
    grant.alloc  = (head.op == heapPkg::opAlloc);
    grant.array  = head.array;
    grant.status = heapPkg::stOk;
    if (grant.alloc) begin
      if (stackTop != '0) begin
        grant.array = freeStack[topIndex];              // Reuse most recently freed
      end else if (usedCount < COUNT_BITS'(ARRAYS)) begin
        grant.array = heapPkg::arrayNum'(usedCount);    // Next fresh number
      end else begin
        grant.status = heapPkg::stOutOfMemory;
      end
    end else if (COUNT_BITS'(head.array) >= usedCount) begin
      grant.status = heapPkg::stNotAllocated;           // Never handed out
    end else if (!allocated[head.array]) begin
      grant.status = heapPkg::stFreed;
    end
  end

  // ------------------------------------------------
  // State update on execute
  // ------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      stackTop  <= '0;
      usedCount <= '0;
      for (int i = 0; i < ARRAYS; i++) begin
        allocated[i] <= 1'b0;
      end
    end else if (execute && grant.status == heapPkg::stOk) begin
      if (grant.alloc) begin
        allocated[grant.array] <= 1'b1;
        if (stackTop != '0) stackTop <= stackTop - 1'b1;   // Pop free stack
        else                usedCount <= usedCount + 1'b1;
      end else if (head.op == heapPkg::opFree) begin
        allocated[grant.array] <= 1'b0;
        stackTop               <= stackTop + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (execute && grant.status == heapPkg::stOk && head.op == heapPkg::opFree)
      freeStack[heapPkg::arrayNum'(stackTop)] <= grant.array;
  end

  // Only used arrays can ever be on the free stack
  assert property (@(posedge clock) disable iff (!resetN) stackTop <= usedCount);

endmodule

`default_nettype wire

/* hw/heapArrayStore.sv */
/*
  Element memory and per-array sizes
  Runs element, size, push, pop and arithmetic ops
*/
`timescale 1ns/100ps
`default_nettype none
`include "heapCfg.svh"

module heapArrayStore (
  input  wire logic              clock,
  input  wire logic              resetN,
  input  wire logic              execute,
  input  wire heapPkg::heapReq   head,
  input  wire heapPkg::heapGrant grant,
  output heapPkg::heapRsp        rsp
);

  localparam int ARRAYS = `HEAP_ARRAYS;
  localparam int LENGTH = `HEAP_ARRAY_LENGTH;

  heapPkg::dataWord  elements [ARRAYS][LENGTH];
  heapPkg::sizeCount sizes    [ARRAYS];
  heapPkg::sizeCount curSize;
  heapPkg::dataWord  curElem;           // Element at head index
  logic              writeEn;
  heapPkg::elemIndex writeIdx;
  heapPkg::dataWord  writeData;
  logic              sizeEn;
  heapPkg::sizeCount newSize;
  logic              commit;            // Request valid and executing

  assign curSize = sizes[grant.array];
  assign curElem = elements[grant.array][head.index];

  // ------------------------------------------------
  // Checks and result data
  // ------------------------------------------------
  always_comb begin
    rsp.status = grant.status;
    rsp.data   = '0;
    writeEn    = 1'b0;
    writeIdx   = head.index;
    writeData  = head.data;
    sizeEn     = 1'b0;
    newSize    = curSize;
    case (head.op)
      heapPkg::opAlloc: begin
        rsp.data = heapPkg::dataWord'(grant.array);
        sizeEn   = 1'b1;
        newSize  = '0;                                  // Fresh array starts empty
      end
      heapPkg::opWrite: begin
        writeEn  = 1'b1;
        rsp.data = head.data;
        if (heapPkg::sizeCount'(head.index) >= curSize) begin
          sizeEn  = 1'b1;
          newSize = heapPkg::sizeCount'(head.index) + 1'b1;
        end
      end
      heapPkg::opRead: begin
        if (heapPkg::sizeCount'(head.index) >= curSize) rsp.status = heapPkg::stOutOfBounds;
        rsp.data = curElem;
      end
      heapPkg::opSize: rsp.data = heapPkg::dataWord'(curSize);
      heapPkg::opPush: begin
        if (curSize == heapPkg::sizeCount'(LENGTH)) rsp.status = heapPkg::stFull;
        writeEn  = 1'b1;
        writeIdx = heapPkg::elemIndex'(curSize);        // Append slot
        rsp.data = head.data;
        sizeEn   = 1'b1;
        newSize  = curSize + 1'b1;
      end
      heapPkg::opPop: begin
        if (curSize == '0) rsp.status = heapPkg::stEmpty;
        rsp.data = elements[grant.array][heapPkg::elemIndex'(curSize - 1'b1)];
        sizeEn   = 1'b1;
        newSize  = curSize - 1'b1;
      end
      heapPkg::opAdd, heapPkg::opSub, heapPkg::opOr, heapPkg::opXor, heapPkg::opAnd: begin
        if (heapPkg::sizeCount'(head.index) >= curSize) rsp.status = heapPkg::stOutOfBounds;
        case (head.op)
          heapPkg::opAdd: writeData = curElem + head.data;  // Wraps at data width
          heapPkg::opSub: writeData = curElem - head.data;
          heapPkg::opOr:  writeData = curElem | head.data;
          heapPkg::opXor: writeData = curElem ^ head.data;
          default:        writeData = curElem & head.data;
        endcase
        writeEn  = 1'b1;
        rsp.data = writeData;                           // New value
      end
      default: ;                                        // Free has no store work
    endcase
    if (grant.status != heapPkg::stOk) rsp.status = grant.status;   // Array check first
    if (rsp.status != heapPkg::stOk) rsp.data = '0;
  end

  assign commit = execute && (rsp.status == heapPkg::stOk);

  // ------------------------------------------------
  // Updates on execute
  // ------------------------------------------------
  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      for (int i = 0; i < ARRAYS; i++) begin
        sizes[i] <= '0;
      end
    end else if (commit && sizeEn) begin
      sizes[grant.array] <= newSize;
    end
  end

  always_ff @(posedge clock) begin
    if (commit && writeEn) elements[grant.array][writeIdx] <= writeData;
  end

  for (genvar a = 0; a < ARRAYS; a++) begin : gSizeCheck
    assert property (@(posedge clock) disable iff (!resetN)
      sizes[a] <= heapPkg::sizeCount'(LENGTH));
  end

endmodule

`default_nettype wire

/* hw/heapResponseSender.sv */
/*
  Response register and output credit counter
  canIssue gates execution while credits remain
*/
`timescale 1ns/100ps
`default_nettype none
`include "heapCfg.svh"

module heapResponseSender (
  input  wire logic            clock,
  input  wire logic            resetN,
  input  wire logic            execute,
  input  wire heapPkg::heapRsp rsp,
  input  wire logic            rspCredit,   // Consumer frees one slot
  output logic                 canIssue,
  output logic                 rspValid,
  output heapPkg::heapRsp      rspData
);

  localparam int CREDITS     = `HEAP_RSP_CREDITS;
  localparam int CREDIT_BITS = $clog2(CREDITS + 1);

  logic [CREDIT_BITS-1:0] credits;

  always_ff @(posedge clock or negedge resetN) begin
    if (!resetN) begin
      credits  <= CREDIT_BITS'(CREDITS);   // Consumer starts empty
      rspValid <= 1'b0;
    end else begin
      rspValid <= execute;                 // One cycle after execute
      case ({execute, rspCredit})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (execute) rspData <= rsp;
  end

  assign canIssue = (credits != '0);

  // Returned credits must never exceed what was handed out
  assert property (@(posedge clock) disable iff (!resetN)
    rspCredit && !execute |-> credits < CREDIT_BITS'(CREDITS));

endmodule

`default_nettype wire

/* hw/heapMemory.sv */
/*
  Array heap top level
  Queue, allocator, array store and response sender
*/
`timescale 1ns/100ps
`default_nettype none

module heapMemory (
  input  wire logic            clock,
  input  wire logic            resetN,
  input  wire logic            reqValid,
  input  wire heapPkg::heapReq reqData,
  output logic                 reqCredit,
  output logic                 rspValid,
  output heapPkg::heapRsp      rspData,
  input  wire logic            rspCredit
);

  logic              headValid;
  logic              canIssue;
  logic              execute;     // Head request runs this cycle
  heapPkg::heapReq   head;
  heapPkg::heapGrant grant;
  heapPkg::heapRsp   rsp;

  assign execute = headValid && canIssue;

  // ------------------------------------------------
  // Request path
  // ------------------------------------------------
  heapRequestQueue queue (
    .clock(clock), .resetN(resetN), .reqValid(reqValid), .reqData(reqData),
    .execute(execute), .headValid(headValid), .head(head), .reqCredit(reqCredit)
  );

  heapAllocator allocator (
    .clock(clock), .resetN(resetN), .execute(execute), .head(head), .grant(grant)
  );

  heapArrayStore store (
    .clock(clock), .resetN(resetN), .execute(execute), .head(head),
    .grant(grant), .rsp(rsp)
  );

  // ------------------------------------------------
  // Response path
  // ------------------------------------------------
  heapResponseSender sender (
    .clock(clock), .resetN(resetN), .execute(execute), .rsp(rsp),
    .rspCredit(rspCredit), .canIssue(canIssue), .rspValid(rspValid),
    .rspData(rspData)
  );

endmodule

`default_nettype wire

/* tb/heapMemoryTb.sv */
/*
  Array heap testbench: clock, reset, credit-gated stimulus,
  reference model, consumer back-pressure and checking assertions
*/
`timescale 1ns/100ps
`default_nettype none
`include "heapCfg.svh"

module heapMemoryTb;

  localparam int ARRAYS = `HEAP_ARRAYS;
  localparam int LENGTH = `HEAP_ARRAY_LENGTH;
  localparam int MASK   = (1 << `HEAP_DATA_BITS) - 1;
  localparam int LIMIT  = 200;            // Cycles before any wait gives up

  localparam int ALLOC    = 0;            // Behavior ids
  localparam int REUSE    = 1;
  localparam int ELEMENT  = 2;
  localparam int STACK    = 3;
  localparam int ARITH    = 4;
  localparam int PRESSURE = 5;

  string testNames [6] = '{"allocation", "freeReuse", "writeRead", "pushPop",
                           "arithmetic", "backPressure"};

  logic            clock;
  logic            resetN;
  logic            reqValid;
  heapPkg::heapReq reqData;
  logic            reqCredit;
  logic            rspValid;
  heapPkg::heapRsp rspData;
  logic            rspCredit;

  int              reqCredits  = `HEAP_QUEUE_DEPTH;  // Client credits
  int              owed        = 0;                  // Responses not yet credited
  logic            holdCredits = 1'b0;               // Consumer stalls
  logic [31:0]     dataState   = 32'h3629;
  logic [31:0]     delayState  = 32'h3629;           // Own stream for credit delays
  heapPkg::heapRsp expQ [$];
  int              testQ [$];
  heapPkg::heapRsp expected;
  int              expTest     = 0;
  logic            expAvail    = 1'b0;
  int              rspErrors   = 0;
  int              otherErrors = 0;

  // --------------------------------------------------
  // Reference model state
  // --------------------------------------------------
  logic mAlloc [ARRAYS];
  int   mUsed = 0;                        // Arrays ever handed out
  int   mFree [$];                        // Freed arrays, newest at back
  int   mSize [ARRAYS];
  int   mElem [ARRAYS][LENGTH];
  logic written [LENGTH];

  heapMemory UUT (
    .clock(clock), .resetN(resetN), .reqValid(reqValid), .reqData(reqData),
    .reqCredit(reqCredit), .rspValid(rspValid), .rspData(rspData), .rspCredit(rspCredit)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic int randomData();
    dataState = xorshift(dataState);
    return int'(dataState) & MASK;
  endfunction

  function automatic heapPkg::heapReq makeReq(input heapPkg::heapOp op, input int array,
                                              input int index, input int data);
    heapPkg::heapReq r;
    r.op    = op;
    r.array = heapPkg::arrayNum'(array);
    r.index = heapPkg::elemIndex'(index);
    r.data  = heapPkg::dataWord'(data);
    return r;
  endfunction

  // Expected response, model updated as the DUT should be
  function automatic heapPkg::heapRsp modelStep(input heapPkg::heapReq r);
    heapPkg::heapRsp res;
    int a;
    int i;
    int d;
    a = r.array;
    i = r.index;
    d = r.data;
    res.status = heapPkg::stOk;
    res.data   = '0;
    if (r.op == heapPkg::opAlloc) begin
      if (mFree.size() > 0) begin
        a = mFree.pop_back();             // Most recently freed
      end else if (mUsed < ARRAYS) begin
        a = mUsed;                        // Next fresh number
        mUsed++;
      end else begin
        res.status = heapPkg::stOutOfMemory;
        return res;
      end
      mAlloc[a] = 1'b1;
      mSize[a]  = 0;
      res.data  = heapPkg::dataWord'(a);
    end else if (a >= mUsed) begin
      res.status = heapPkg::stNotAllocated;
    end else if (!mAlloc[a]) begin
      res.status = heapPkg::stFreed;
    end else begin
      case (r.op)
        heapPkg::opFree: begin
          mAlloc[a] = 1'b0;
          mFree.push_back(a);
        end
        heapPkg::opWrite: begin
          mElem[a][i] = d;
          if (i >= mSize[a]) mSize[a] = i + 1;   // Grow to cover index
          res.data = r.data;                     // Echo of stored value
        end
        heapPkg::opSize: res.data = heapPkg::dataWord'(mSize[a]);
        heapPkg::opPush: begin
          if (mSize[a] == LENGTH) begin
            res.status = heapPkg::stFull;
          end else begin
            mElem[a][mSize[a]] = d;
            mSize[a]++;
            res.data = r.data;
          end
        end
        heapPkg::opPop: begin
          if (mSize[a] == 0) begin
            res.status = heapPkg::stEmpty;
          end else begin
            mSize[a]--;
            res.data = heapPkg::dataWord'(mElem[a][mSize[a]]);   // Last element
          end
        end
        default: begin                    // Read and arithmetic
          if (i >= mSize[a]) begin
            res.status = heapPkg::stOutOfBounds;
          end else begin
            case (r.op)
              heapPkg::opAdd: mElem[a][i] = (mElem[a][i] + d) & MASK;
              heapPkg::opSub: mElem[a][i] = (mElem[a][i] - d) & MASK;
              heapPkg::opOr:  mElem[a][i] = mElem[a][i] | d;
              heapPkg::opXor: mElem[a][i] = mElem[a][i] ^ d;
              heapPkg::opAnd: mElem[a][i] = mElem[a][i] & d;
              default: ;                  // Plain read
            endcase
            res.data = heapPkg::dataWord'(mElem[a][i]);
          end
        end
      endcase
    end
    return res;
  endfunction

  task automatic giveUp(input string why);
    $display("%s", why);
    $display("Errors found");
    $finish;
  endtask

  // Called on a falling edge, returns on the next one
  task automatic sendReq(input heapPkg::heapReq req, input int test);
    int waited;
    waited = 0;
    while (reqCredits == 0) begin
      @(negedge clock);
      waited++;
      if (waited > LIMIT) giveUp("Timed out waiting for a request credit");
    end
    reqValid = 1'b1;
    reqData  = req;
    reqCredits--;
    expQ.push_back(modelStep(req));
    testQ.push_back(test);
    @(negedge clock);
    reqValid = 1'b0;
  endtask

  // --------------------------------------------------
  // Credit tracking, expected head and consumer
  // --------------------------------------------------
  always @(posedge clock) begin
    if (reqCredit) reqCredits++;
    if (rspValid) begin
      owed++;
      if (expQ.size() > 0) begin
        void'(expQ.pop_front());
        void'(testQ.pop_front());
      end
    end
    expAvail = (expQ.size() > 0);
    if (expAvail) begin
      expected = expQ[0];
      expTest  = testQ[0];
    end
  end

  always @(negedge clock) begin
    rspCredit = 1'b0;
    if (!holdCredits && owed > 0) begin
      delayState = xorshift(delayState);
      if (delayState[1:0] != 2'b00) begin   // Random gaps
        rspCredit = 1'b1;
        owed--;
      end
    end
  end

  assert property (@(posedge clock) disable iff (!resetN) rspValid |-> expAvail)
    else begin
      otherErrors++;
      $display("A response arrived with no request outstanding");
    end

  assert property (@(posedge clock) disable iff (!resetN)
    rspValid && expAvail |-> rspData == expected)
    else begin
      rspErrors++;
      $display("Fail %s: expected %h, actual %h", testNames[$sampled(expTest)],
               $sampled(expected), $sampled(rspData));
    end

  assert property (@(posedge clock) reqCredits >= 0 && reqCredits <= `HEAP_QUEUE_DEPTH)
    else begin
      otherErrors++;
      $display("Client request credits left the valid range: %0d", reqCredits);
    end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    int k;
    int n;
    int idx;
    int waited;
    reqValid  = 1'b0;
    reqData   = '0;
    rspCredit = 1'b0;
    resetN    = 1'b0;
    for (k = 0; k < ARRAYS; k++) begin
      mAlloc[k] = 1'b0;
      mSize[k]  = 0;
    end
    repeat (3) @(posedge clock);
    @(negedge clock);
    resetN = 1'b1;

    sendReq(makeReq(heapPkg::opAlloc, 0, 0, 0), ALLOC);
    sendReq(makeReq(heapPkg::opRead, ARRAYS - 1, 0, 0), ALLOC);   // Never handed out
    for (k = 1; k <= ARRAYS; k++)         // Last one runs out of memory
      sendReq(makeReq(heapPkg::opAlloc, 0, 0, 0), ALLOC);

    sendReq(makeReq(heapPkg::opFree, 2, 0, 0), REUSE);
    sendReq(makeReq(heapPkg::opFree, 1, 0, 0), REUSE);
    sendReq(makeReq(heapPkg::opAlloc, 0, 0, 0), REUSE);
    sendReq(makeReq(heapPkg::opAlloc, 0, 0, 0), REUSE);
    sendReq(makeReq(heapPkg::opFree, 3, 0, 0), REUSE);
    sendReq(makeReq(heapPkg::opRead, 3, 0, 0), REUSE);
    sendReq(makeReq(heapPkg::opSize, 3, 0, 0), REUSE);
    sendReq(makeReq(heapPkg::opPush, 3, 0, 5), REUSE);
    sendReq(makeReq(heapPkg::opFree, 3, 0, 0), REUSE);          // Double free

    for (k = 0; k < LENGTH; k++) written[k] = 1'b0;
    for (k = 0; k < 6; k++) begin         // Top index stays unwritten
      idx = randomData() % (LENGTH - 1);
      written[idx] = 1'b1;
      sendReq(makeReq(heapPkg::opWrite, 0, idx, randomData()), ELEMENT);
    end
    for (k = 0; k < LENGTH; k++)
      if (written[k] || k >= mSize[0]) sendReq(makeReq(heapPkg::opRead, 0, k, 0), ELEMENT);
    sendReq(makeReq(heapPkg::opSize, 0, 0, 0), ELEMENT);

    for (k = 0; k <= LENGTH; k++)
      sendReq(makeReq(heapPkg::opPush, 1, 0, randomData()), STACK);
    for (k = 0; k <= LENGTH; k++)
      sendReq(makeReq(heapPkg::opPop, 1, 0, 0), STACK);

    for (k = 0; k < LENGTH; k++)
      sendReq(makeReq(heapPkg::opWrite, 2, k, randomData()), ARITH);
    for (k = 0; k < 10; k++) begin
      idx = randomData() % LENGTH;
      sendReq(makeReq(heapPkg::heapOp'(int'(heapPkg::opAdd) + k % 5), 2, idx,
                      randomData()), ARITH);
    end
    for (k = 0; k < LENGTH; k++)
      sendReq(makeReq(heapPkg::opRead, 2, k, 0), ARITH);

    @(posedge clock);
    holdCredits = 1'b1;                   // Consumer stops returning credits
    @(negedge clock);
    fork
      begin
        repeat (40) @(posedge clock);
        holdCredits = 1'b0;
      end
      for (n = 0; n < 14; n++)
        sendReq(makeReq((n % 3 == 0) ? heapPkg::opAdd : heapPkg::opRead, 2,
                        n % LENGTH, randomData()), PRESSURE);
    join

    waited = 0;
    while (expQ.size() > 0) begin
      @(negedge clock);
      waited++;
      if (waited > LIMIT) giveUp("Timed out waiting for outstanding responses");
    end
    repeat (2) @(negedge clock);
    $display("Response mismatches: %0d, other errors: %0d", rspErrors, otherErrors);
    if (rspErrors == 0 && otherErrors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
+incdir+hw
hw/heapPkg.sv
hw/heapRequestQueue.sv
hw/heapAllocator.sv
hw/heapArrayStore.sv
hw/heapResponseSender.sv
hw/heapMemory.sv
tb/heapMemoryTb.sv
